//--- Bender.yml
package:
  name: mul_unit

sources:
  - src/mul_arith_pkg.sv
  - src/mul_ctrl_pkg.sv
  - src/mul_sign_prep.sv
  - src/wallace_tree.sv
  - src/mul_sign_fix.sv
  - src/mul_cycle_counter.sv
  - src/mul_ctrl_fsm.sv
  - src/mul_unit_top.sv
  - target: test
    files:
      - verification/mul_unit_checker.sv
      - verification/mul_unit_tb.sv

//--- list.f
src/mul_arith_pkg.sv
src/mul_ctrl_pkg.sv
src/mul_sign_prep.sv
src/wallace_tree.sv
src/mul_sign_fix.sv
src/mul_cycle_counter.sv
src/mul_ctrl_fsm.sv
src/mul_unit_top.sv
verification/mul_unit_checker.sv
verification/mul_unit_tb.sv

//--- src/mul_arith_pkg.sv
`default_nettype none

package mul_arith_pkg;

    // operand width, product is twice as wide
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // raw operand or magnitude
    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    // full width product
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // multiplication kind, reserved code runs as unsigned
    typedef enum logic [1:0] {
        MUL_UU   = 2'd0,
        MUL_SS   = 2'd1,
        MUL_SU   = 2'd2,
        MUL_RSVD = 2'd3
    } mul_kind_e;

    // request bundle at the unit boundary
    typedef struct packed {
        mul_kind_e kind;
        operand_t  a;
        operand_t  b;
    } mul_req_t;

    // conditioned operands plus result sign
    typedef struct packed {
        operand_t mag_a;
        operand_t mag_b;
        logic     neg;
    } mag_pair_t;

    // unsigned magnitude product plus result sign
    typedef struct packed {
        product_t mag;
        logic     neg;
    } mag_prod_t;

endpackage

`default_nettype wire

//--- src/mul_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mul_ctrl_fsm
(
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    input  logic expired,
    output logic load,
    output logic done_next,
    output logic busy,
    output logic done
);

    import mul_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // next state and strobes
    always_comb
    begin
        state_nxt = state;
        load      = 1'b0;
        done_next = 1'b0;
        case (state)
            IDLE:
            begin
                // accept only here, starts in RUN or DONE are dropped
                if (start)
                begin
                    load      = 1'b1;
                    state_nxt = RUN;
                end
            end
            RUN:
            begin
                // product sits at the sign fix input
                if (expired)
                begin
                    done_next = 1'b1;
                    state_nxt = DONE;
                end
            end
            DONE:
            begin
                // single done cycle
                state_nxt = IDLE;
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == DONE);

endmodule

`default_nettype wire

//--- src/mul_ctrl_pkg.sv
`default_nettype none

package mul_ctrl_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } ctrl_state_e;

    // cycles from the accepting edge to done
    localparam int MUL_LATENCY = 3;

    // wide enough for MUL_LATENCY - 1
    localparam int LAT_CNT_WIDTH = 2;

endpackage

`default_nettype wire

//--- src/mul_cycle_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mul_cycle_counter
(
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    output logic expired
);

    import mul_ctrl_pkg::*;

    logic [LAT_CNT_WIDTH-1:0] cnt;

    // loaded at accept, hits zero one cycle before the done edge
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt <= '0;
        end
        else if (load)
        begin
            cnt <= LAT_CNT_WIDTH'(MUL_LATENCY - 1);
        end
        else if (cnt != '0)
        begin
            cnt <= cnt - 1'b1;
        end
    end

    // only looked at while the controller is in RUN
    assign expired = (cnt == '0);

endmodule

`default_nettype wire

//--- src/mul_sign_fix.sv
`timescale 1ns/10ps
`default_nettype none

module mul_sign_fix
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     en,
    input  mul_arith_pkg::mag_prod_t prod,
    output mul_arith_pkg::product_t  p
);

    import mul_arith_pkg::*;

    product_t p_d;

    // negate magnitude for a negative result
    assign p_d = prod.neg ? product_t'(~prod.mag + 1'b1) : prod.mag;

    // result register, holds until the next done_next
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            p <= '0;
        end
        else if (en)
        begin
            p <= p_d;
        end
    end

endmodule

`default_nettype wire

//--- src/mul_sign_prep.sv
`timescale 1ns/10ps
`default_nettype none

module mul_sign_prep
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  mul_arith_pkg::mul_req_t  req,
    output mul_arith_pkg::mag_pair_t mags
);

    import mul_arith_pkg::*;

    logic      a_neg;
    logic      b_neg;
    logic      neg_d;
    operand_t  abs_a;
    operand_t  abs_b;

    // which operands count as negative for this kind
    always_comb
    begin
        a_neg = 1'b0;
        b_neg = 1'b0;
        neg_d = 1'b0;
        case (req.kind)
            MUL_SS:
            begin
                a_neg = req.a[OPERAND_WIDTH-1];
                b_neg = req.b[OPERAND_WIDTH-1];
                // a zero operand must not flip the sign
                neg_d = (a_neg ^ b_neg) && (req.a != '0) && (req.b != '0);
            end
            MUL_SU:
            begin
                // b is plain unsigned here
                a_neg = req.a[OPERAND_WIDTH-1];
                neg_d = a_neg;
            end
            default:
            begin
                // MUL_UU and MUL_RSVD, both operands taken as is
                neg_d = 1'b0;
            end
        endcase
    end

    // two's complement magnitude where needed
    assign abs_a = a_neg ? operand_t'(~req.a + 1'b1) : req.a;
    assign abs_b = b_neg ? operand_t'(~req.b + 1'b1) : req.b;

    // captured only at the accepting edge, held for the rest of the op
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mags <= '0;
        end
        else if (load)
        begin
            mags.mag_a <= abs_a;
            mags.mag_b <= abs_b;
            mags.neg   <= neg_d;
        end
    end

endmodule

`default_nettype wire

//--- src/mul_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit_top
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  mul_arith_pkg::mul_req_t req,
    output logic                    busy,
    output logic                    done,
    output mul_arith_pkg::product_t p
);

    import mul_arith_pkg::*;

    // control strobes
    logic      load;
    logic      done_next;
    logic      expired;
    // data between stages
    mag_pair_t mags;
    mag_prod_t prod;

    mul_ctrl_fsm u_ctrl_fsm
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .expired   (expired),
        .load      (load),
        .done_next (done_next),
        .busy      (busy),
        .done      (done)
    );

    mul_cycle_counter u_cycle_counter
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load),
        .expired (expired)
    );

    // stage 1, magnitudes and sign
    mul_sign_prep u_sign_prep
    (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .req    (req),
        .mags   (mags)
    );

    // stage 2, reduction and add
    wallace_tree #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) u_wallace_tree
    (
        .clk    (clk),
        .arst_n (arst_n),
        .mags   (mags),
        .prod   (prod)
    );

    // stage 3, sign applied and result held
    mul_sign_fix u_sign_fix
    (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (done_next),
        .prod   (prod),
        .p      (p)
    );

endmodule

`default_nettype wire

//--- src/wallace_tree.sv
`timescale 1ns/10ps
`default_nettype none

module wallace_tree
#(
    parameter int OPERAND_WIDTH = mul_arith_pkg::OPERAND_WIDTH
)
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  mul_arith_pkg::mag_pair_t mags,
    output mul_arith_pkg::mag_prod_t prod
);

    localparam int PW = 2 * OPERAND_WIDTH;

    // rows left after a number of 3:2 layers
    // each full group of three becomes two rows
    function automatic int rows_after(input int n, input int layers);
        int r;
        r = n;
        for (int k = 0; k < layers; k++)
        begin
            r = r - r / 3;
        end
        return r;
    endfunction

    // layers needed to get down to two rows
    function automatic int layer_count(input int n);
        int r;
        int l;
        r = n;
        l = 0;
        while (r > 2)
        begin
            r = r - r / 3;
            l++;
        end
        return l;
    endfunction

    localparam int NUM_LAYERS = layer_count(OPERAND_WIDTH);

    logic [OPERAND_WIDTH-1:0] op_a;
    logic [OPERAND_WIDTH-1:0] op_b;
    // row array per layer, index 0 holds the partial products
    logic [PW-1:0] rows [NUM_LAYERS+1][OPERAND_WIDTH];
    logic [PW-1:0] sum_q;
    logic [PW-1:0] carry_q;
    logic          neg_q;

    assign op_a = mags.mag_a;
    assign op_b = mags.mag_b;

    // partial products, one shifted copy of a per bit of b
    for (genvar i = 0; i < OPERAND_WIDTH; i++)
    begin : g_pp
        assign rows[0][i] = op_b[i] ? (PW'(op_a) << i) : '0;
    end

    // carry-save layers
    for (genvar l = 0; l < NUM_LAYERS; l++)
    begin : g_layer
        localparam int R_IN   = rows_after(OPERAND_WIDTH, l);
        localparam int GROUPS = R_IN / 3;
        localparam int R_OUT  = R_IN - GROUPS;

        for (genvar g = 0; g < GROUPS; g++)
        begin : g_csa
            // full adder per column, carries move up one bit
            assign rows[l+1][2*g] = rows[l][3*g] ^ rows[l][3*g+1] ^ rows[l][3*g+2];
            assign rows[l+1][2*g+1] = ((rows[l][3*g] & rows[l][3*g+1])
                                     | (rows[l][3*g] & rows[l][3*g+2])
                                     | (rows[l][3*g+1] & rows[l][3*g+2])) << 1;
        end

        // leftover rows pass down untouched
        for (genvar r = 3 * GROUPS; r < R_IN; r++)
        begin : g_pass
            assign rows[l+1][r-GROUPS] = rows[l][r];
        end

        // unused slots tied off
        for (genvar r = R_OUT; r < OPERAND_WIDTH; r++)
        begin : g_tie
            assign rows[l+1][r] = '0;
        end
    end

    // two carry-save rows plus sign, captured every cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sum_q   <= '0;
            carry_q <= '0;
            neg_q   <= 1'b0;
        end
        else
        begin
            sum_q   <= rows[NUM_LAYERS][0];
            carry_q <= rows[NUM_LAYERS][1];
            neg_q   <= mags.neg;
        end
    end

    // final carry-propagate add
    assign prod.mag = sum_q + carry_q;
    assign prod.neg = neg_q;

endmodule

`default_nettype wire

//--- verification/mul_unit_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit_checker
(
    input logic clk,
    input logic arst_n,
    input logic load,
    input logic busy,
    input logic done
);

    import mul_ctrl_pkg::*;

    // count of failed assertions
    int unsigned assert_failures = 0;

    // done is a one-cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else
        begin
            assert_failures++;
            $error("done stayed high for more than one cycle");
        end

    // done exactly MUL_LATENCY cycles after the accepting edge
    done_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        load |=> (!done) [*MUL_LATENCY] ##1 done)
        else
        begin
            assert_failures++;
            $error("done did not follow load at the expected latency");
        end

    // no done without an accepted op behind it
    done_needs_load: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(load, MUL_LATENCY + 1))
        else
        begin
            assert_failures++;
            $error("done without a matching load");
        end

    // idle right out of reset
    busy_low_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy)
        else
        begin
            assert_failures++;
            $error("busy high after reset release");
        end

endmodule

`default_nettype wire

//--- verification/mul_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb;

    import mul_arith_pkg::*;

    localparam int          CLK_PERIOD       = 8;
    localparam int          RESET_CYCLES     = 4;
    // accepting edge to done, as given by the handshake timing
    localparam int          EXPECTED_LATENCY = 3;
    localparam int          WAIT_LIMIT       = 20;
    localparam int          RANDOM_ROWS      = 24;
    localparam logic [31:0] SEED             = 32'hda0f_1c99;

    // one stimulus row with its expected product
    typedef struct packed {
        mul_kind_e kind;
        operand_t  a;
        operand_t  b;
        logic      extra_start;
        product_t  expected;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     start;
    mul_req_t req;
    logic     busy;
    logic     done;
    product_t p;

    row_t table_q[$];

    mul_unit_top UUT
    (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .p      (p)
    );

    // handshake assertions sit next to the controller
    bind mul_ctrl_fsm mul_unit_checker u_checker
    (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .busy   (busy),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input product_t got, input product_t exp);
        if (got !== exp)
        begin
            $display("ERROR: time %0t signal %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not show up within %0d cycles", what, WAIT_LIMIT);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout waiting for %s", what);
    endtask

    // sign-extend what the kind treats as signed, then a 32 bit multiply
    function automatic product_t reference_product(input mul_kind_e kind, input operand_t a,
                                                   input operand_t b);
        logic     a_signed;
        logic     b_signed;
        product_t ext_a;
        product_t ext_b;
        a_signed = (kind == MUL_SS) || (kind == MUL_SU);
        b_signed = (kind == MUL_SS);
        ext_a = a_signed ? {{OPERAND_WIDTH{a[OPERAND_WIDTH-1]}}, a} : {{OPERAND_WIDTH{1'b0}}, a};
        ext_b = b_signed ? {{OPERAND_WIDTH{b[OPERAND_WIDTH-1]}}, b} : {{OPERAND_WIDTH{1'b0}}, b};
        return ext_a * ext_b;
    endfunction

    task automatic add_row(input mul_kind_e kind, input operand_t a, input operand_t b,
                           input logic extra, input product_t expected);
        row_t row;
        row.kind        = kind;
        row.a           = a;
        row.b           = b;
        row.extra_start = extra;
        row.expected    = expected;
        table_q.push_back(row);
    endtask

    // one operation from start pulse through the cycles after done
    task automatic run_row(input row_t row, input product_t prev_p);
        int       lat;
        mul_req_t cur;
        mul_req_t alt;
        cur.kind = row.kind;
        cur.a    = row.a;
        cur.b    = row.b;
        // different operands for the start that must be dropped
        alt.kind = MUL_UU;
        alt.a    = ~row.a;
        alt.b    = row.b ^ 16'h5a5a;
        @(posedge clk);
        start <= 1'b1;
        req   <= cur;
        // accepting edge
        @(posedge clk);
        start <= 1'b0;
        lat = 0;
        do
        begin
            @(posedge clk);
            lat++;
            if (row.extra_start && lat == 1)
            begin
                start <= 1'b1;
                req   <= alt;
            end
            else if (lat == 2)
            begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (!done)
            begin
                // old product still on p while running
                check_value("p", p, prev_p);
                check_value("busy", busy, 1);
                if (lat >= WAIT_LIMIT)
                begin
                    report_timeout("done");
                end
            end
        end
        while (!done);
        check_value("latency", lat, EXPECTED_LATENCY);
        check_value("p", p, row.expected);
        // single done cycle, then idle with p held
        @(negedge clk);
        check_value("done", done, 0);
        check_value("busy", busy, 0);
        check_value("p", p, row.expected);
        @(negedge clk);
        check_value("p", p, row.expected);
    endtask

    initial
    begin
        int unsigned failures;
        mul_kind_e   kind;
        operand_t    a;
        operand_t    b;
        logic        extra;
        product_t    prev_p;
        void'($urandom(SEED));
        start  = 1'b0;
        req    = '0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // quiet outputs before any start
        repeat (2)
        begin
            @(negedge clk);
            check_value("busy", busy, 0);
            check_value("done", done, 0);
            check_value("p", p, 0);
        end

        // unsigned, reserved code runs as unsigned
        add_row(MUL_UU,   16'h0003, 16'h0005, 1'b0, 32'h0000_000f);
        add_row(MUL_UU,   16'hffff, 16'hffff, 1'b0, 32'hfffe_0001);
        add_row(MUL_UU,   16'h0000, 16'h1234, 1'b0, 32'h0000_0000);
        add_row(MUL_RSVD, 16'hffff, 16'h0002, 1'b0, 32'h0001_fffe);
        // signed times signed
        add_row(MUL_SS,   16'hfffe, 16'h0003, 1'b0, 32'hffff_fffa);
        add_row(MUL_SS,   16'h8000, 16'h8000, 1'b0, 32'h4000_0000);
        add_row(MUL_SS,   16'h8000, 16'hffff, 1'b0, 32'h0000_8000);
        add_row(MUL_SS,   16'hffff, 16'h0000, 1'b0, 32'h0000_0000);
        add_row(MUL_SS,   16'h0000, 16'h8000, 1'b0, 32'h0000_0000);
        add_row(MUL_SS,   16'h7fff, 16'h7fff, 1'b0, 32'h3fff_0001);
        // signed a, unsigned b
        add_row(MUL_SU,   16'hffff, 16'hffff, 1'b0, 32'hffff_0001);
        add_row(MUL_SU,   16'h8000, 16'hffff, 1'b0, 32'h8000_8000);
        add_row(MUL_SU,   16'h1234, 16'h8000, 1'b0, 32'h091a_0000);
        add_row(MUL_SU,   16'hfffe, 16'h0000, 1'b0, 32'h0000_0000);
        // second start while busy must be dropped
        add_row(MUL_SS,   16'hffff, 16'hffff, 1'b1, 32'h0000_0001);
        add_row(MUL_UU,   16'h00ff, 16'h0101, 1'b1, 32'h0000_ffff);

        for (int i = 0; i < RANDOM_ROWS; i++)
        begin
            kind  = mul_kind_e'($urandom_range(3, 0));
            a     = ($urandom_range(7, 0) == 0) ? 16'h8000 : operand_t'($urandom);
            b     = operand_t'($urandom);
            extra = ($urandom_range(3, 0) == 0);
            add_row(kind, a, b, extra, reference_product(kind, a, b));
        end

        prev_p = '0;
        foreach (table_q[i])
        begin
            run_row(table_q[i], prev_p);
            prev_p = table_q[i].expected;
        end

        // give the last assertions time to sample
        repeat (2) @(posedge clk);
        failures = UUT.u_ctrl_fsm.u_checker.assert_failures;
        if (failures == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("SIMULATION FAILED");
            $fatal(1, "%0d handshake assertions failed", failures);
        end
    end

endmodule

`default_nettype wire
